//--- rtl/trigger_cfg_pkg.sv
// trigger path configuration: widths, channel count, default FIFO depth

package trigger_cfg_pkg;

    // ------------------------------------------------------------------
    // channel and record field widths
    // ------------------------------------------------------------------
    parameter int NUM_CHAN    = 5;  // digitizer channels
    parameter int TRIG_NUM_W  = 24; // global trigger number
    parameter int TIMESTAMP_W = 44; // 40 MHz ticks
    parameter int TRIG_TYPE_W = 5;  // muon fill, laser, pedestal, ...
    parameter int DELAY_W     = 16; // trigger to channel delay, in cycles

    // ------------------------------------------------------------------
    // record buffering
    // ------------------------------------------------------------------
    parameter int DEFAULT_FIFO_DEPTH = 8; // records per FIFO

endpackage

//--- rtl/trigger_types_pkg.sv
// trigger path types: scalar fields, trigger record and acquisition record

package trigger_types_pkg;

    import trigger_cfg_pkg::*;

    // ------------------------------------------------------------------
    // scalar fields
    // ------------------------------------------------------------------
    typedef logic [TRIG_NUM_W-1:0]  trig_num_t;  // counts from 1
    typedef logic [TIMESTAMP_W-1:0] timestamp_t; // free running tick count
    typedef logic [TRIG_TYPE_W-1:0] trig_type_t;
    typedef logic [NUM_CHAN-1:0]    chan_mask_t; // one bit per channel

    // ------------------------------------------------------------------
    // records passed through the FIFOs
    // ------------------------------------------------------------------

    // written by the TTC receiver for each accepted trigger, 73 bits
    typedef struct packed {
        timestamp_t timestamp; // tick count in the trigger cycle
        trig_num_t  trig_num;
        trig_type_t trig_type;
    } trig_info_t;

    // written by the acquisition controller once all channels are done, 34 bits
    typedef struct packed {
        trig_num_t  trig_num;
        trig_type_t trig_type;
        chan_mask_t chan_mask; // channels that took part
    } acq_event_t;

endpackage

//--- rtl/credit_fifo.sv
// synchronous record FIFO with type parameter payload and one credit per pop
`timescale 1ns/1ps

module credit_fifo #(
    parameter int  DEPTH     = 8,
    parameter type payload_t = logic [7:0]
) (
    input  logic     ttc_clk,
    input  logic     reset,
    input  logic     push,     // writer holds a credit
    input  payload_t wr_data,
    input  logic     pop,
    output logic     rd_valid,
    output payload_t rd_data,  // oldest record
    output logic     credit    // one cycle per pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [CNT_W-1:0] count; // occupancy
    logic             do_pop;

    // wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign do_pop   = pop && rd_valid;

    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            count  <= count + CNT_W'(push) - CNT_W'(do_pop);
            credit <= do_pop; // slot handed back to the writer
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (push) mem[wr_ptr] <= wr_data;
    end

endmodule

//--- rtl/ttc_trigger_receiver.sv
// TTC trigger receiver: trigger numbering, timestamp counter, rate error, record writes
`timescale 1ns/1ps

module ttc_trigger_receiver #(
    parameter int FIFO_DEPTH = trigger_cfg_pkg::DEFAULT_FIFO_DEPTH // initial credits
) (
    input  logic ttc_clk,
    input  logic reset,
    input  logic rst_trigger_num,
    input  logic rst_trigger_timestamp,

    input  logic                          trigger,   // TTC trigger
    input  trigger_types_pkg::trig_type_t trig_type,
    input  logic                          acq_ready, // controller can take a trigger
    input  logic                          credit,    // one per record popped

    output logic                          push,
    output trigger_types_pkg::trig_info_t wr_data,
    output logic                          acq_trigger,
    output trigger_types_pkg::trig_num_t  acq_trig_num,
    output trigger_types_pkg::trig_type_t acq_trig_type,
    output trigger_types_pkg::trig_num_t  trig_num,
    output logic                          error_trig_rate
);

    import trigger_types_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    timestamp_t       ts_cnt;     // free running
    trig_num_t        num_base;   // number after a pending channel B reset
    logic [CNT_W-1:0] credit_cnt; // free trigger FIFO slots
    logic             accept;

    assign num_base = rst_trigger_num ? '0 : trig_num;
    assign accept   = trigger && acq_ready && (credit_cnt != '0);

    // controller sees the same number and type as the record
    assign acq_trig_num  = wr_data.trig_num;
    assign acq_trig_type = wr_data.trig_type;

    // ------------------------------------------------------------------
    // timestamp
    // ------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (reset || rst_trigger_timestamp) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // numbering, credits, rate error
    // ------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            trig_num        <= '0;
            push            <= 1'b0;
            acq_trigger     <= 1'b0;
            credit_cnt      <= CNT_W'(FIFO_DEPTH);
            error_trig_rate <= 1'b0;
        end else begin
            trig_num    <= accept ? num_base + 1'b1 : num_base; // dropped trigger keeps number
            push        <= accept;
            acq_trigger <= accept; // same cycle as the record push
            credit_cnt  <= credit_cnt - CNT_W'(accept) + CNT_W'(credit);
            if (trigger && !accept) begin
                error_trig_rate <= 1'b1; // sticky until reset
            end
        end
    end

    // record of cycle N, written in N+1
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            wr_data.timestamp <= ts_cnt;
            wr_data.trig_num  <= num_base + 1'b1;
            wr_data.trig_type <= trig_type;
        end
    end

endmodule

//--- rtl/channel_acq_controller.sv
// channel acquisition controller: delayed channel trigger, done collection, record writes
`timescale 1ns/1ps

module channel_acq_controller #(
    parameter int FIFO_DEPTH = trigger_cfg_pkg::DEFAULT_FIFO_DEPTH // initial credits
) (
    input  logic ttc_clk,
    input  logic reset,

    input  trigger_types_pkg::chan_mask_t       chan_en,    // sampled at acq_trigger
    input  logic [trigger_cfg_pkg::DELAY_W-1:0] trig_delay, // extra cycles before chan_trig

    input  logic                          acq_trigger,
    input  trigger_types_pkg::trig_num_t  acq_trig_num,
    input  trigger_types_pkg::trig_type_t acq_trig_type,
    input  trigger_types_pkg::chan_mask_t chan_dones,
    input  logic                          credit,

    output logic                          acq_ready,
    output trigger_types_pkg::chan_mask_t chan_enable,
    output trigger_types_pkg::chan_mask_t chan_trig,
    output logic                          push,
    output trigger_types_pkg::acq_event_t wr_data
);

    import trigger_cfg_pkg::*;
    import trigger_types_pkg::*;

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {S_IDLE, S_DELAY, S_COLLECT, S_WRITE} state_t;

    state_t             state;
    logic [DELAY_W-1:0] delay_cnt;
    chan_mask_t         mask;      // latched chan_en
    chan_mask_t         seen;      // done bits seen so far
    chan_mask_t         seen_next;
    trig_num_t          num;
    trig_type_t         typ;
    logic [CNT_W-1:0]   credit_cnt; // free acquisition FIFO slots
    logic               fire;       // chan_trig cycle

    assign fire      = (state == S_DELAY) && (delay_cnt == '0);
    assign seen_next = seen | (chan_dones & mask);

    // ------------------------------------------------------------------
    // channel side and record outputs
    // ------------------------------------------------------------------
    assign chan_trig   = fire ? mask : '0;
    assign chan_enable = (fire || state == S_COLLECT) ? mask : '0; // held until all done
    assign push        = (state == S_WRITE) || (fire && mask == '0); // empty mask writes at once
    assign acq_ready   = (state == S_IDLE) && !acq_trigger && (credit_cnt != '0);

    assign wr_data.trig_num  = num;
    assign wr_data.trig_type = typ;
    assign wr_data.chan_mask = mask;

    // ------------------------------------------------------------------
    // FSM and credits
    // ------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            state      <= S_IDLE;
            credit_cnt <= CNT_W'(FIFO_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - CNT_W'(push) + CNT_W'(credit);
            case (state)
                S_IDLE:    if (acq_trigger) state <= S_DELAY;
                S_DELAY:   if (fire) state <= (mask == '0) ? S_IDLE : S_COLLECT;
                S_COLLECT: if (seen_next == mask) state <= S_WRITE; // last done this cycle
                S_WRITE:   state <= S_IDLE;
                default:   state <= S_IDLE;
            endcase
        end
    end

    // trigger context and delay countdown
    always_ff @(posedge ttc_clk) begin
        if (state == S_IDLE && acq_trigger) begin
            mask      <= chan_en;
            num       <= acq_trig_num;
            typ       <= acq_trig_type;
            delay_cnt <= trig_delay; // reaches zero trig_delay+1 cycles later
        end else if (state == S_DELAY && !fire) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
        if (fire) begin
            seen <= chan_dones & mask;
        end else if (state == S_COLLECT) begin
            seen <= seen_next; // dones may come in different cycles
        end
    end

endmodule

//--- rtl/trigger_processor.sv
// trigger processor: record pairing, readout start and event counting
`timescale 1ns/1ps

module trigger_processor (
    input  logic ttc_clk,
    input  logic reset,

    // trigger record FIFO
    input  logic                          trig_valid,
    input  trigger_types_pkg::trig_info_t trig_rec,
    output logic                          trig_pop,

    // acquisition record FIFO
    input  logic                          acq_valid,
    input  trigger_types_pkg::acq_event_t acq_rec,
    output logic                          acq_pop,

    // command manager
    input  logic                          readout_ready,
    input  logic                          readout_done,
    output logic                          initiate_readout,
    output trigger_types_pkg::trig_num_t  ttc_event_num,
    output trigger_types_pkg::trig_num_t  ttc_trig_num,
    output trigger_types_pkg::trig_type_t ttc_trig_type,
    output trigger_types_pkg::timestamp_t ttc_trig_timestamp,
    output trigger_types_pkg::chan_mask_t readout_chans
);

    typedef enum logic [1:0] {S_WAIT, S_START, S_BUSY} state_t;

    state_t state;
    logic   pair; // both records present, command manager idle

    assign pair             = (state == S_WAIT) && trig_valid && acq_valid && readout_ready;
    assign trig_pop         = pair; // records leave together
    assign acq_pop          = pair;
    assign initiate_readout = (state == S_START); // one cycle

    // ------------------------------------------------------------------
    // FSM and event count
    // ------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (reset) begin
            state         <= S_WAIT;
            ttc_event_num <= '0;
        end else begin
            case (state)
                S_WAIT: begin
                    if (pair) begin
                        state         <= S_START;
                        ttc_event_num <= ttc_event_num + 1'b1;
                    end
                end
                S_START: state <= S_BUSY;
                S_BUSY:  if (readout_done) state <= S_WAIT; // readout complete
                default: state <= S_WAIT;
            endcase
        end
    end

    // record outputs, held until the next pairing
    always_ff @(posedge ttc_clk) begin
        if (pair) begin
            ttc_trig_num       <= trig_rec.trig_num;
            ttc_trig_type      <= trig_rec.trig_type;
            ttc_trig_timestamp <= trig_rec.timestamp;
            readout_chans      <= acq_rec.chan_mask; // channels that acquired
        end
    end

endmodule

//--- rtl/trigger_top.sv
// trigger path top level: receiver, acquisition controller, record FIFOs, processor
`timescale 1ns/1ps

module trigger_top #(
    parameter int FIFO_DEPTH = trigger_cfg_pkg::DEFAULT_FIFO_DEPTH // records per FIFO
) (
    input  logic ttc_clk, // 40 MHz TTC clock
    input  logic reset,

    input  logic rst_trigger_num,       // TTC channel B
    input  logic rst_trigger_timestamp, // TTC channel B

    // trigger and configuration
    input  logic                                ttc_trigger,
    input  trigger_types_pkg::trig_type_t       trig_type,
    input  trigger_types_pkg::chan_mask_t       chan_en,
    input  logic [trigger_cfg_pkg::DELAY_W-1:0] trig_delay,

    // channel interface
    input  trigger_types_pkg::chan_mask_t chan_dones,
    output trigger_types_pkg::chan_mask_t chan_enable,
    output trigger_types_pkg::chan_mask_t chan_trig,

    // command manager interface
    input  logic                          readout_ready, // command manager idle
    input  logic                          readout_done,  // readout finished
    output logic                          initiate_readout,
    output trigger_types_pkg::trig_num_t  ttc_event_num,
    output trigger_types_pkg::trig_num_t  ttc_trig_num,
    output trigger_types_pkg::trig_type_t ttc_trig_type,
    output trigger_types_pkg::timestamp_t ttc_trig_timestamp,
    output trigger_types_pkg::chan_mask_t readout_chans,

    // status
    output trigger_types_pkg::trig_num_t trig_num, // latest accepted trigger
    output logic                         error_trig_rate // sticky, trigger dropped
);

    import trigger_types_pkg::*;

    // ------------------------------------------------------------------
    // interconnect
    // ------------------------------------------------------------------
    logic       acq_ready, acq_trigger; // receiver <-> controller
    trig_num_t  acq_trig_num;
    trig_type_t acq_trig_type;

    logic       trig_push, trig_pop, trig_valid, trig_credit; // trigger record FIFO
    trig_info_t trig_wr_data, trig_rd_data;

    logic       acq_push, acq_pop, acq_valid, acq_credit; // acquisition record FIFO
    acq_event_t acq_wr_data, acq_rd_data;

    // ------------------------------------------------------------------
    // instances
    // ------------------------------------------------------------------
    ttc_trigger_receiver #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) ttc_trigger_receiver_i (
        .ttc_clk              (ttc_clk),
        .reset                (reset),
        .rst_trigger_num      (rst_trigger_num),
        .rst_trigger_timestamp(rst_trigger_timestamp),
        .trigger              (ttc_trigger),
        .trig_type            (trig_type),
        .acq_ready            (acq_ready),
        .credit               (trig_credit),
        .push                 (trig_push),
        .wr_data              (trig_wr_data),
        .acq_trigger          (acq_trigger),
        .acq_trig_num         (acq_trig_num),
        .acq_trig_type        (acq_trig_type),
        .trig_num             (trig_num),
        .error_trig_rate      (error_trig_rate)
    );

    channel_acq_controller #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) channel_acq_controller_i (
        .ttc_clk      (ttc_clk),
        .reset        (reset),
        .chan_en      (chan_en),
        .trig_delay   (trig_delay),
        .acq_trigger  (acq_trigger),
        .acq_trig_num (acq_trig_num),
        .acq_trig_type(acq_trig_type),
        .chan_dones   (chan_dones),
        .credit       (acq_credit),
        .acq_ready    (acq_ready),
        .chan_enable  (chan_enable),
        .chan_trig    (chan_trig),
        .push         (acq_push),
        .wr_data      (acq_wr_data)
    );

    // trigger records: timestamp, number, type
    credit_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(trig_info_t)
    ) trig_fifo (
        .ttc_clk (ttc_clk),
        .reset   (reset),
        .push    (trig_push),
        .wr_data (trig_wr_data),
        .pop     (trig_pop),
        .rd_valid(trig_valid),
        .rd_data (trig_rd_data),
        .credit  (trig_credit)
    );

    // acquisition records: number, type, channel mask
    credit_fifo #(
        .DEPTH    (FIFO_DEPTH),
        .payload_t(acq_event_t)
    ) acq_fifo (
        .ttc_clk (ttc_clk),
        .reset   (reset),
        .push    (acq_push),
        .wr_data (acq_wr_data),
        .pop     (acq_pop),
        .rd_valid(acq_valid),
        .rd_data (acq_rd_data),
        .credit  (acq_credit)
    );

    trigger_processor trigger_processor_i (
        .ttc_clk           (ttc_clk),
        .reset             (reset),
        .trig_valid        (trig_valid),
        .trig_rec          (trig_rd_data),
        .acq_valid         (acq_valid),
        .acq_rec           (acq_rd_data),
        .readout_ready     (readout_ready),
        .readout_done      (readout_done),
        .trig_pop          (trig_pop),
        .acq_pop           (acq_pop),
        .initiate_readout  (initiate_readout),
        .ttc_event_num     (ttc_event_num),
        .ttc_trig_num      (ttc_trig_num),
        .ttc_trig_type     (ttc_trig_type),
        .ttc_trig_timestamp(ttc_trig_timestamp),
        .readout_chans     (readout_chans)
    );

endmodule

//--- testbench/trigger_top_tb.sv
// trigger path testbench with clock, reset, channel and command manager models, stimulus and checks
`timescale 1ns/1ps

module trigger_top_tb;

    import trigger_cfg_pkg::*;
    import trigger_types_pkg::*;

    localparam int FIFO_DEPTH      = 4;
    localparam int CLK_PERIOD      = 100;           // ns
    localparam int DRIVE_DLY       = 5;             // ns after the rising edge
    localparam int NUM_TESTS       = 21;            // triggers sent over the whole run
    localparam int TEST_CYCLES     = 300;           // worst case per trigger
    localparam int MARGIN_CYCLES   = 500;
    localparam int WATCHDOG_NS     = (NUM_TESTS * TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
    localparam int READOUT_TIMEOUT = 200;           // cycles
    localparam int STALL_GAP       = 30;            // cycles between stalled triggers
    localparam int ENABLE_TIMEOUT  = 20;            // cycles from trigger to chan_enable

    // expected readout queued when the trigger is accepted
    typedef struct packed {
        trig_num_t  num;
        trig_type_t typ;
        chan_mask_t chans;
        timestamp_t ts;
    } readout_exp_t;

    // DUT inputs
    logic       ttc_clk = 1'b0;
    logic       reset, rst_trigger_num, rst_trigger_timestamp;
    logic       ttc_trigger, readout_ready;
    logic       readout_done = 1'b0; // command manager model
    trig_type_t trig_type;
    chan_mask_t chan_en;
    chan_mask_t chan_dones = '0;     // channel model
    logic [DELAY_W-1:0] trig_delay;

    // DUT outputs
    chan_mask_t chan_enable, chan_trig, readout_chans;
    logic       initiate_readout, error_trig_rate;
    trig_num_t  ttc_event_num, ttc_trig_num, trig_num;
    trig_type_t ttc_trig_type;
    timestamp_t ttc_trig_timestamp;

    // run bookkeeping
    integer seed = 55;
    int     errors = 0;
    int     cyc = 0;
    int     rd_count = 0;   // readouts seen
    int     target = 0;     // readouts expected so far
    logic   trig_accept;    // stimulus expects this trigger to be taken

    // reference model state updated on the falling edge
    readout_exp_t expected [$];
    readout_exp_t exp_rd, entry;
    chan_mask_t   exp_chan_trig, sched_mask;
    trig_num_t    exp_trig_num, num_reg = '0, exp_event_num, event_reg = '0;
    logic         exp_err, err_reg = 1'b0, rd_unexpected = 1'b0;
    logic         busy_now = 1'b0, busy_before = 1'b0;
    logic         ready_now = 1'b0, ready_last = 1'b0;
    logic         reset_last = 1'b0, after_reset = 1'b0;
    int           sched_cycle = -1, ts_base = 0;

    // model process state
    int         chan_wait [NUM_CHAN];
    chan_mask_t chan_armed = '0;
    int         done_wait = 0;

    trigger_top #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) trigger_top_i (
        .ttc_clk              (ttc_clk),
        .reset                (reset),
        .rst_trigger_num      (rst_trigger_num),
        .rst_trigger_timestamp(rst_trigger_timestamp),
        .ttc_trigger          (ttc_trigger),
        .trig_type            (trig_type),
        .chan_en              (chan_en),
        .trig_delay           (trig_delay),
        .chan_dones           (chan_dones),
        .chan_enable          (chan_enable),
        .chan_trig            (chan_trig),
        .readout_ready        (readout_ready),
        .readout_done         (readout_done),
        .initiate_readout     (initiate_readout),
        .ttc_event_num        (ttc_event_num),
        .ttc_trig_num         (ttc_trig_num),
        .ttc_trig_type        (ttc_trig_type),
        .ttc_trig_timestamp   (ttc_trig_timestamp),
        .readout_chans        (readout_chans),
        .trig_num             (trig_num),
        .error_trig_rate      (error_trig_rate)
    );

    always #(CLK_PERIOD / 2) ttc_clk = ~ttc_clk;

    always @(posedge ttc_clk) cyc <= cyc + 1;

    // ------------------------------------------------------------------
    // channel and command manager models
    // ------------------------------------------------------------------
    always @(posedge ttc_clk) begin
        #DRIVE_DLY;
        for (int ch = 0; ch < NUM_CHAN; ch++) begin
            if (!chan_enable[ch]) begin // drop done once the acquisition is over
                chan_dones[ch] = 1'b0;
                chan_armed[ch] = 1'b0;
            end else if (!chan_armed[ch]) begin
                chan_armed[ch] = 1'b1;
                chan_wait[ch]  = 1 + ($unsigned($random(seed)) % 6);
            end else if (chan_wait[ch] > 0) begin
                chan_wait[ch] = chan_wait[ch] - 1;
                if (chan_wait[ch] == 0) chan_dones[ch] = 1'b1; // held until disabled
            end
        end
    end

    always @(posedge ttc_clk) begin
        #DRIVE_DLY;
        readout_done = 1'b0;
        if (done_wait > 0) begin
            done_wait = done_wait - 1;
            if (done_wait == 0) readout_done = 1'b1; // one cycle pulse
        end
        if (initiate_readout) done_wait = 1 + ($unsigned($random(seed)) % 8);
    end

    // ------------------------------------------------------------------
    // reference model updated mid cycle
    // ------------------------------------------------------------------
    always @(negedge ttc_clk) begin
        exp_chan_trig = (cyc == sched_cycle) ? sched_mask : '0;
        exp_trig_num  = num_reg;  // register value for this cycle
        exp_err       = err_reg;
        after_reset   = reset_last && !reset;
        reset_last    = reset;
        ready_last    = ready_now; // ready in the pop cycle
        ready_now     = readout_ready;
        busy_before   = busy_now;
        rd_unexpected = 1'b0;
        if (reset) begin
            num_reg     = '0;
            event_reg   = '0;
            err_reg     = 1'b0;
            busy_now    = 1'b0;
            sched_cycle = -1;
            ts_base     = cyc + 1; // timestamp counts from zero next cycle
            expected.delete();
        end else begin
            if (rst_trigger_num) num_reg = '0;
            if (ttc_trigger && trig_accept) begin
                num_reg     = num_reg + 1'b1;
                entry.num   = num_reg;
                entry.typ   = trig_type;
                entry.chans = chan_en;
                entry.ts    = timestamp_t'(cyc - ts_base);
                expected.push_back(entry);
                sched_cycle = cyc + int'(trig_delay) + 2;
                sched_mask  = chan_en;
            end else if (ttc_trigger) begin
                err_reg = 1'b1; // dropped trigger sets the sticky error
            end
            if (initiate_readout) begin
                event_reg     = event_reg + 1'b1;
                exp_event_num = event_reg;
                if (expected.size() == 0) rd_unexpected = 1'b1;
                else exp_rd = expected.pop_front();
                busy_now = 1'b1;
                rd_count = rd_count + 1;
            end
            if (readout_done) busy_now = 1'b0;
        end
    end

    task automatic flag_error(input string msg);
        errors = errors + 1;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    chan_trig_check: assert property (@(posedge ttc_clk) disable iff (reset)
        chan_trig == exp_chan_trig)
        else flag_error("chan_trig differs from the delayed channel mask");
    trig_num_check: assert property (@(posedge ttc_clk) disable iff (reset)
        trig_num == exp_trig_num)
        else flag_error("trig_num wrong");
    rate_error_check: assert property (@(posedge ttc_clk) disable iff (reset)
        error_trig_rate == exp_err)
        else flag_error("error_trig_rate wrong");
    unexpected_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !rd_unexpected)
        else flag_error("initiate_readout without an accepted trigger");
    rd_num_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || ttc_trig_num == exp_rd.num)
        else flag_error("ttc_trig_num wrong at readout");
    rd_type_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || ttc_trig_type == exp_rd.typ)
        else flag_error("ttc_trig_type wrong at readout");
    rd_chans_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || readout_chans == exp_rd.chans)
        else flag_error("readout_chans wrong at readout");
    rd_ts_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || ttc_trig_timestamp == exp_rd.ts)
        else flag_error("ttc_trig_timestamp off from the trigger cycle");
    event_num_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || ttc_event_num == exp_event_num)
        else flag_error("ttc_event_num wrong at readout");
    overlap_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !initiate_readout || (!busy_before && ready_last))
        else flag_error("readout started while busy or not ready");
    reset_check: assert property (@(posedge ttc_clk) disable iff (reset)
        !after_reset || (chan_trig == '0 && chan_enable == '0 && !initiate_readout
                         && !error_trig_rate))
        else flag_error("outputs not idle after reset");

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic next_cycle();
        @(posedge ttc_clk);
        #DRIVE_DLY;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        idle_cycles(10);
        reset = 1'b0;
    endtask

    // one cycle trigger with mask and delay held until the next one
    task automatic send_trigger(input logic accept, input chan_mask_t mask);
        trig_type   = trig_type_t'($random(seed));
        chan_en     = mask;
        trig_delay  = DELAY_W'($unsigned($random(seed)) % 8);
        trig_accept = accept;
        ttc_trigger = 1'b1;
        next_cycle();
        ttc_trigger = 1'b0;
        trig_accept = 1'b0;
    endtask

    task automatic wait_for_readouts(input int count);
        int waited;
        waited = 0;
        while ((rd_count < count || busy_now) && waited < READOUT_TIMEOUT) begin
            next_cycle();
            waited = waited + 1;
        end
        if (waited >= READOUT_TIMEOUT) begin
            errors = errors + 1;
            $display("readout %0d did not complete within %0d cycles", count,
                     READOUT_TIMEOUT);
        end
    endtask

    // stops in the chan_trig cycle of the trigger just sent
    task automatic wait_channels_enabled();
        int waited;
        waited = 0;
        while (chan_enable == '0 && waited < ENABLE_TIMEOUT) begin
            next_cycle();
            waited = waited + 1;
        end
        if (chan_enable == '0) begin
            errors = errors + 1;
            $display("channels were never enabled after the trigger");
        end
    endtask

    task automatic accepted_trigger(input chan_mask_t mask);
        send_trigger(1'b1, mask);
        target = target + 1;
        wait_for_readouts(target);
        idle_cycles(3);
    endtask

    initial begin
        reset                 = 1'b1;
        rst_trigger_num       = 1'b0;
        rst_trigger_timestamp = 1'b0;
        ttc_trigger           = 1'b0;
        trig_accept           = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        readout_ready         = 1'b1;
        apply_reset();
        idle_cycles(2);

        // spaced triggers with no channels on the fourth
        for (int i = 0; i < 8; i++) begin
            accepted_trigger((i == 3) ? chan_mask_t'('0) : chan_mask_t'($random(seed)));
        end

        // numbering restarts from 1
        rst_trigger_num = 1'b1;
        next_cycle();
        rst_trigger_num = 1'b0;
        for (int i = 0; i < 4; i++) accepted_trigger(chan_mask_t'($random(seed)));

        // stall fills the FIFOs so later triggers drop
        readout_ready = 1'b0;
        idle_cycles(2);
        for (int i = 0; i < 6; i++) begin
            send_trigger(i < FIFO_DEPTH, chan_mask_t'($random(seed)));
            idle_cycles(STALL_GAP);
        end
        readout_ready = 1'b1;
        target = target + FIFO_DEPTH;
        wait_for_readouts(target);
        idle_cycles(60);
        drain_count_check: assert (rd_count == target)
            else flag_error("readout count after the stall differs from FIFO depth");

        // reset in mid acquisition clears channels, rate error, numbering and event count
        send_trigger(1'b1, '1);
        wait_channels_enabled();
        apply_reset();
        idle_cycles(2);
        for (int i = 0; i < 2; i++) accepted_trigger(chan_mask_t'($random(seed)));
        idle_cycles(5);

        $display("run complete: %0d readouts, %0d errors", rd_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("run timed out before the tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

//--- sources.f
rtl/trigger_cfg_pkg.sv
rtl/trigger_types_pkg.sv
rtl/credit_fifo.sv
rtl/ttc_trigger_receiver.sv
rtl/channel_acq_controller.sv
rtl/trigger_processor.sv
rtl/trigger_top.sv
testbench/trigger_top_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the trigger path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module trigger_top_tb -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtrigger_top_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$LOG"; then
    exit 1
fi

exit 0
